/* Bender.yml */
package:
  name: conv_engine

sources:
  # package first, then leaf modules up to the top
  - logic/conv_pkg.sv
  - logic/conv_pe.sv
  - logic/conv_lane_skew.sv
  - logic/conv_addr_gen.sv
  - logic/conv_acc_relu.sv
  - logic/conv_top.sv
  - target: simulation
    files:
      - dv/conv_tb.sv

/* dv/conv_tb.sv */
`timescale 1ns/1ps

module conv_tb;
	import conv_pkg::*;

	localparam int img_rows = 6;
	localparam int img_cols = 6;
	localparam int kern     = 4;
	localparam int out_rows = img_rows - kern + 1;
	localparam int out_cols = img_cols - kern + 1;
	localparam int in_depth = 8 * img_rows * img_cols;
	localparam int wt_depth = 64 * 8 * kern * kern;
	localparam int out_depth = 64 * out_rows * out_cols;

	localparam int fill_random = 0;
	localparam int fill_neg    = 1; // positive pixels and negative weights
	localparam int fill_min    = 2; // every lane at -128

	logic       clk = 1'b0;
	logic       rst;
	logic       start;
	size_code_t ci, co;
	addr_t      in_addr, wt_addr, out_addr;
	word_t      in_data = '0;
	word_t      wt_data = '0;
	acc_t       out_data;
	logic       out_wren, done;

	word_t in_mem [in_depth];
	word_t wt_mem [wt_depth];
	acc_t  exp_out [out_depth];
	addr_t exp_in_q [$];
	addr_t exp_wt_q [$];
	addr_t in_rd = '0;
	addr_t wt_rd = '0;

	logic [31:0] lfsr_state = 32'h1a6b623a;
	int          order [16];

	always #4 clk = ~clk;

	conv_top #(
		.img_rows (img_rows),
		.img_cols (img_cols),
		.kern     (kern)
	) i_conv_top (
		.clk      (clk),
		.rst      (rst),
		.start    (start),
		.ci       (ci),
		.co       (co),
		.in_addr  (in_addr),
		.wt_addr  (wt_addr),
		.in_data  (in_data),
		.wt_data  (wt_data),
		.out_addr (out_addr),
		.out_data (out_data),
		.out_wren (out_wren),
		.done     (done)
	);

	// ----------------------------------------
	// RAM models latch the address on the rising edge
	// ----------------------------------------
	always @(posedge clk) begin
		in_rd <= in_addr;
		wt_rd <= wt_addr;
	end

	always @(negedge clk) begin
		in_data <= in_mem[in_rd];
		wt_data <= wt_mem[wt_rd];
	end

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? (s >> 1) ^ 32'ha3000000 : s >> 1; // galois form
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	task automatic abort_run();
		$display("SOME TESTS FAILED");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_value(input string name, input logic [63:0] got,
			input logic [63:0] exp);
		if (got !== exp) begin
			$display("error: %s got 0x%0h expected 0x%0h", name, got, exp);
			abort_run();
		end
	endtask

	// one address pair per cycle until the walk is over
	task automatic compare_addresses();
		if (exp_in_q.size() > 0) begin
			check_value("in_addr", in_addr, exp_in_q.pop_front());
			check_value("wt_addr", wt_addr, exp_wt_q.pop_front());
		end
	endtask

	task automatic fill_mems(input int mode, input size_code_t ci_c, input size_code_t co_c);
		int          n_in, n_wt;
		logic [31:0] r;
		logic [7:0]  b;
		n_in = groups_of(ci_c) * img_rows * img_cols;
		n_wt = lanes * groups_of(co_c) * groups_of(ci_c) * kern * kern;
		for (int a = 0; a < n_in; a++)
			for (int l = 0; l < lanes; l++) begin
				r = rand_bits(mode == fill_neg ? 7 : 8);
				b = mode == fill_min ? 8'h80 : (mode == fill_neg ? {1'b0, r[6:0]} : r[7:0]);
				in_mem[a][l*8 +: 8] = b;
			end
		for (int a = 0; a < n_wt; a++)
			for (int l = 0; l < lanes; l++) begin
				r = rand_bits(mode == fill_neg ? 6 : 8);
				b = mode == fill_min ? 8'h80 : (mode == fill_neg ? {2'b10, r[5:0]} : r[7:0]);
				wt_mem[a][l*8 +: 8] = b;
			end
	endtask

	// expected RAM addresses in walk order and ReLU results by output address
	task automatic build_model(input size_code_t ci_c, input size_code_t co_c);
		int     groups, maps, ia, wa, px, wv;
		longint sum;
		groups = groups_of(ci_c);
		maps   = lanes * groups_of(co_c);
		exp_in_q.delete();
		exp_wt_q.delete();
		for (int m = 0; m < maps; m++)
			for (int r = 0; r < out_rows; r++)
				for (int c = 0; c < out_cols; c++) begin
					sum = 0;
					for (int g = 0; g < groups; g++)
						for (int ky = 0; ky < kern; ky++)
							for (int kx = 0; kx < kern; kx++) begin
								ia = g * img_rows * img_cols + (r + ky) * img_cols + c + kx;
								wa = ((m * groups + g) * kern + ky) * kern + kx;
								exp_in_q.push_back(ia);
								exp_wt_q.push_back(wa);
								for (int l = 0; l < lanes; l++) begin
									px = $signed(in_mem[ia][l*8 +: 8]);
									wv = $signed(wt_mem[wa][l*8 +: 8]);
									sum += px * wv;
								end
							end
					exp_out[m * out_rows * out_cols + r * out_cols + c] =
						sum < 0 ? '0 : acc_t'(sum);
				end
	endtask

	task automatic run_job(input size_code_t ci_c, input size_code_t co_c, input int mode);
		int n_out, limit, cycles, wr_count, idle;
		fill_mems(mode, ci_c, co_c);
		build_model(ci_c, co_c);
		n_out = lanes * groups_of(co_c) * out_rows * out_cols;
		limit = n_out * groups_of(ci_c) * kern * kern + 100;
		ci    = ci_c;
		co    = co_c;
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
		check_value("done", done, 0); // cleared by start
		compare_addresses(); // first address right after start
		wr_count = 0;
		cycles   = 0;
		while (!done) begin
			if (cycles == limit) begin
				$display("timeout: done did not rise within %0d cycles", limit);
				abort_run();
			end
			@(negedge clk);
			cycles++;
			compare_addresses();
			if (out_wren) begin
				if (wr_count >= n_out) begin
					$display("more output writes than the %0d expected", n_out);
					abort_run();
				end
				check_value("out_addr", out_addr, wr_count);
				check_value("out_data", out_data, exp_out[out_addr]);
				wr_count++;
			end
		end
		check_value("write count", wr_count, n_out);
		// done must hold while idle
		idle = 4 + rand_bits(4);
		repeat (idle) begin
			@(negedge clk);
			check_value("done", done, 1);
			check_value("out_wren", out_wren, 0);
		end
	endtask

	// ----------------------------------------
	// main sequence
	// ----------------------------------------
	initial begin
		int j, t;
		rst   = 1'b1;
		start = 1'b0;
		ci    = '0;
		co    = '0;
		for (int a = 0; a < in_depth; a++)
			in_mem[a] = '0;
		for (int a = 0; a < wt_depth; a++)
			wt_mem[a] = '0;
		repeat (16) @(negedge clk);
		rst = 1'b0;

		repeat (10) begin
			@(negedge clk);
			check_value("out_wren", out_wren, 0);
			check_value("done", done, 0);
		end

		run_job(2'd0, 2'd0, fill_random);

		// all ci/co pairs in shuffled order
		for (int i = 0; i < 16; i++)
			order[i] = i;
		for (int i = 15; i > 0; i--) begin
			j = rand_bits(8) % (i + 1);
			t = order[i];
			order[i] = order[j];
			order[j] = t;
		end
		for (int i = 0; i < 16; i++)
			run_job(size_code_t'(order[i] % 4), size_code_t'(order[i] / 4), fill_random);

		run_job(2'd1, 2'd0, fill_neg);
		run_job(2'd3, 2'd0, fill_min); // 1024 products at full magnitude
		run_job(2'd0, 2'd1, fill_random);

		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

/* files.f */
logic/conv_pkg.sv
logic/conv_pe.sv
logic/conv_lane_skew.sv
logic/conv_addr_gen.sv
logic/conv_acc_relu.sv
logic/conv_top.sv
dv/conv_tb.sv

/* logic/conv_acc_relu.sv */
`timescale 1ns/1ps

module conv_acc_relu (
	input  logic            clk,
	input  logic            rst,
	input  logic            start,
	input  conv_pkg::acc_t  chain_sum,
	input  logic            sk_valid,
	input  logic            sk_first,
	input  logic            sk_last,
	input  logic            sk_job_last,
	output conv_pkg::addr_t out_addr,
	output conv_pkg::acc_t  out_data,
	output logic            out_wren,
	output logic            done
);
	import conv_pkg::*;

	acc_t  acc;
	acc_t  total;
	addr_t next_addr;
	logic  wr_evt;

	assign total  = sk_first ? chain_sum : acc + chain_sum;
	assign wr_evt = sk_valid && sk_last;

	// ----------------------------------------
	// per pixel accumulation and ReLU
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (sk_valid)
			acc <= total;
		if (wr_evt)
			out_data <= total[$bits(acc_t)-1] ? '0 : total; // clamp negatives
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			out_wren  <= 1'b0;
			out_addr  <= '0;
			next_addr <= '0;
			done      <= 1'b0;
		end else begin
			out_wren <= wr_evt;
			if (wr_evt) begin
				out_addr  <= next_addr;
				next_addr <= sk_job_last ? '0 : next_addr + 1'b1; // wraps per job
			end
			if (wr_evt && sk_job_last)
				done <= 1'b1;
			else if (start)
				done <= 1'b0;
		end
	end

	// no writes once the job has been reported done
	assert property (@(posedge clk) disable iff (rst) out_wren |-> !$past(done));

endmodule

/* logic/conv_addr_gen.sv */
`timescale 1ns/1ps

module conv_addr_gen #(
	parameter int img_rows = 8,
	parameter int img_cols = 8,
	parameter int kern     = 4
) (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 start,
	input  conv_pkg::size_code_t ci,
	input  conv_pkg::size_code_t co,
	output conv_pkg::addr_t      in_addr,
	output conv_pkg::addr_t      wt_addr,
	output logic                 tag_valid,
	output logic                 tag_first,
	output logic                 tag_last,
	output logic                 tag_job_last
);
	import conv_pkg::*;

	localparam int out_rows = img_rows - kern + 1;
	localparam int out_cols = img_cols - kern + 1;
	localparam int row_w    = $clog2(out_rows + 1);
	localparam int col_w    = $clog2(out_cols + 1);
	localparam int k_w      = $clog2(kern + 1);

	gen_state_t state;

	logic [5:0]       map_cnt;
	logic [row_w-1:0] row_cnt;
	logic [col_w-1:0] col_cnt;
	logic [2:0]       grp_cnt;
	logic [k_w-1:0]   ky_cnt;
	logic [k_w-1:0]   kx_cnt;
	logic [3:0]       drain_cnt; // waits out the pipeline

	logic [3:0] groups;
	logic       kx_last, ky_last, grp_last, col_last, row_last, map_last;
	logic       pix_first, pix_last, job_last;

	assign groups = groups_of(ci);

	assign kx_last  = kx_cnt == kern - 1;
	assign ky_last  = ky_cnt == kern - 1;
	assign grp_last = grp_cnt == groups - 1;
	assign col_last = col_cnt == out_cols - 1;
	assign row_last = row_cnt == out_rows - 1;
	assign map_last = map_cnt == lanes * groups_of(co) - 1;

	assign pix_first = kx_cnt == 0 && ky_cnt == 0 && grp_cnt == 0;
	assign pix_last  = kx_last && ky_last && grp_last;
	assign job_last  = pix_last && col_last && row_last && map_last;

	// ----------------------------------------
	// addresses straight from the counters
	// ----------------------------------------
	assign in_addr = addr_t'(grp_cnt * img_rows * img_cols
		+ (row_cnt + ky_cnt) * img_cols + (col_cnt + kx_cnt));
	assign wt_addr = addr_t'(((map_cnt * groups + grp_cnt) * kern + ky_cnt) * kern + kx_cnt);

	always_ff @(posedge clk) begin
		if (rst) begin
			state     <= idle;
			map_cnt   <= '0;
			row_cnt   <= '0;
			col_cnt   <= '0;
			grp_cnt   <= '0;
			ky_cnt    <= '0;
			kx_cnt    <= '0;
			drain_cnt <= '0;
		end else begin
			case (state)
				idle: if (start) begin
					state   <= run;
					map_cnt <= '0;
					row_cnt <= '0;
					col_cnt <= '0;
					grp_cnt <= '0;
					ky_cnt  <= '0;
					kx_cnt  <= '0;
				end
				run: begin
					kx_cnt <= kx_last ? '0 : kx_cnt + 1'b1; // innermost
					if (kx_last)
						ky_cnt <= ky_last ? '0 : ky_cnt + 1'b1;
					if (kx_last && ky_last)
						grp_cnt <= grp_last ? '0 : grp_cnt + 1'b1;
					if (pix_last)
						col_cnt <= col_last ? '0 : col_cnt + 1'b1;
					if (pix_last && col_last)
						row_cnt <= row_last ? '0 : row_cnt + 1'b1;
					if (pix_last && col_last && row_last)
						map_cnt <= map_last ? '0 : map_cnt + 1'b1;
					if (job_last) begin
						state     <= drain;
						drain_cnt <= '0;
					end
				end
				drain: begin
					if (drain_cnt == lanes)
						state <= idle;
					drain_cnt <= drain_cnt + 1'b1;
				end
				default: state <= idle;
			endcase
		end
	end

	// tags follow the RAM read latency
	always_ff @(posedge clk) begin
		if (rst) begin
			tag_valid    <= 1'b0;
			tag_first    <= 1'b0;
			tag_last     <= 1'b0;
			tag_job_last <= 1'b0;
		end else begin
			tag_valid    <= state == run;
			tag_first    <= state == run && pix_first;
			tag_last     <= state == run && pix_last;
			tag_job_last <= state == run && job_last;
		end
	end

	// a job must finish before the next start
	assert property (@(posedge clk) disable iff (rst) state == run |-> !start);

endmodule

/* logic/conv_lane_skew.sv */
`timescale 1ns/1ps

module conv_lane_skew (
	input  logic            clk,
	input  logic            rst,
	input  conv_pkg::word_t in_data,
	input  conv_pkg::word_t wt_data,
	input  logic            tag_valid,
	input  logic            tag_first,
	input  logic            tag_last,
	input  logic            tag_job_last,
	output conv_pkg::pix_t  x_lane [conv_pkg::lanes],
	output conv_pkg::pix_t  w_lane [conv_pkg::lanes],
	output logic            sk_valid,
	output logic            sk_first,
	output logic            sk_last,
	output logic            sk_job_last
);
	import conv_pkg::*;

	localparam int pw = $bits(pix_t);

	logic [3:0] tag_sr [lanes];

	// ----------------------------------------
	// lane i waits i cycles for its partial sum
	// ----------------------------------------
	for (genvar i = 0; i < lanes; i++) begin : g_lane
		if (i == 0) begin : g_direct
			assign x_lane[i] = pix_t'(in_data[pw-1:0]);
			assign w_lane[i] = pix_t'(wt_data[pw-1:0]);
		end else begin : g_delay
			logic [2*pw-1:0] sr [i]; // {w, x} per stage

			always_ff @(posedge clk) begin
				sr[0] <= {wt_data[i*pw +: pw], in_data[i*pw +: pw]};
				for (int k = 1; k < i; k++)
					sr[k] <= sr[k-1];
			end

			assign {w_lane[i], x_lane[i]} = sr[i-1];
		end
	end

	// tags ride alongside the full chain depth
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int k = 0; k < lanes; k++)
				tag_sr[k] <= '0;
		end else begin
			tag_sr[0] <= {tag_valid, tag_first, tag_last, tag_job_last};
			for (int k = 1; k < lanes; k++)
				tag_sr[k] <= tag_sr[k-1];
		end
	end

	assign {sk_valid, sk_first, sk_last, sk_job_last} = tag_sr[lanes-1];

endmodule

/* logic/conv_pe.sv */
`timescale 1ns/1ps

module conv_pe (
	input  logic           clk,
	input  conv_pkg::pix_t x,
	input  conv_pkg::pix_t w,
	input  conv_pkg::acc_t sum_in,
	output conv_pkg::acc_t sum_out
);
	import conv_pkg::*;

	prod_t prod;

	assign prod = x * w; // signed 8x8

	always_ff @(posedge clk) begin
		sum_out <= sum_in + acc_t'(prod); // sign extended
	end

endmodule

/* logic/conv_pkg.sv */
package conv_pkg;

	// ----------------------------------------
	// datapath widths
	// ----------------------------------------
	localparam int lanes = 8; // channels per word and chain length

	typedef logic signed [7:0]  pix_t;      // one input pixel or weight
	typedef logic [lanes*8-1:0] word_t;     // lane 0 in the low byte
	typedef logic signed [15:0] prod_t;     // single lane product
	typedef logic signed [25:0] acc_t;      // holds 1024 worst-case products
	typedef logic [19:0]        addr_t;
	typedef logic [1:0]         size_code_t; // 8, 16, 32 or 64

	// ----------------------------------------
	// address generator FSM
	// ----------------------------------------
	typedef enum logic [1:0] {
		idle,
		run,
		drain
	} gen_state_t;

	// channel groups of eight for a size code
	function automatic logic [3:0] groups_of(size_code_t code);
		logic [3:0] n;
		case (code)
			2'd0: n = 4'd1;
			2'd1: n = 4'd2;
			2'd2: n = 4'd4;
			default: n = 4'd8;
		endcase
		return n;
	endfunction

endpackage

/* logic/conv_top.sv */
`timescale 1ns/1ps

module conv_top #(
	parameter int img_rows = 8,
	parameter int img_cols = 8,
	parameter int kern     = 4
) (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 start,
	input  conv_pkg::size_code_t ci,
	input  conv_pkg::size_code_t co,
	output conv_pkg::addr_t      in_addr,
	output conv_pkg::addr_t      wt_addr,
	input  conv_pkg::word_t      in_data,
	input  conv_pkg::word_t      wt_data,
	output conv_pkg::addr_t      out_addr,
	output conv_pkg::acc_t       out_data,
	output logic                 out_wren,
	output logic                 done
);
	import conv_pkg::*;

	logic tag_valid, tag_first, tag_last, tag_job_last;
	logic sk_valid, sk_first, sk_last, sk_job_last;

	pix_t x_lane [lanes];
	pix_t w_lane [lanes];
	acc_t pe_sum [lanes+1]; // pe_sum[i] feeds PE i
	acc_t chain_sum;

	conv_addr_gen #(
		.img_rows (img_rows),
		.img_cols (img_cols),
		.kern     (kern)
	) i_addr_gen (
		.clk          (clk),
		.rst          (rst),
		.start        (start),
		.ci           (ci),
		.co           (co),
		.in_addr      (in_addr),
		.wt_addr      (wt_addr),
		.tag_valid    (tag_valid),
		.tag_first    (tag_first),
		.tag_last     (tag_last),
		.tag_job_last (tag_job_last)
	);

	conv_lane_skew i_lane_skew (
		.clk          (clk),
		.rst          (rst),
		.in_data      (in_data),
		.wt_data      (wt_data),
		.tag_valid    (tag_valid),
		.tag_first    (tag_first),
		.tag_last     (tag_last),
		.tag_job_last (tag_job_last),
		.x_lane       (x_lane),
		.w_lane       (w_lane),
		.sk_valid     (sk_valid),
		.sk_first     (sk_first),
		.sk_last      (sk_last),
		.sk_job_last  (sk_job_last)
	);

	// ----------------------------------------
	// systolic chain
	// ----------------------------------------
	assign pe_sum[0] = '0;

	for (genvar i = 0; i < lanes; i++) begin : g_pe
		conv_pe i_pe (
			.clk     (clk),
			.x       (x_lane[i]),
			.w       (w_lane[i]),
			.sum_in  (pe_sum[i]),
			.sum_out (pe_sum[i+1])
		);
	end

	assign chain_sum = pe_sum[lanes];

	conv_acc_relu i_acc_relu (
		.clk         (clk),
		.rst         (rst),
		.start       (start),
		.chain_sum   (chain_sum),
		.sk_valid    (sk_valid),
		.sk_first    (sk_first),
		.sk_last     (sk_last),
		.sk_job_last (sk_job_last),
		.out_addr    (out_addr),
		.out_data    (out_data),
		.out_wren    (out_wren),
		.done        (done)
	);

endmodule
